/* Makefile */
# Verilator build and run for the multiply/divide unit

VERILATOR ?= verilator
TOP       ?= tb_imuldiv
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= TEST PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* rtl/imuldiv_pkg.sv */
// --------------------
// shared types for the multiply/divide unit
// operand width is fixed at 32 bits and every message layout depends on it
// --------------------

package imuldiv_pkg;

  // --------------------
  // request side
  // --------------------

  // function code, carried with every request
  typedef enum logic [1:0] {
    MD_MUL  = 2'd0,
    MD_DIV  = 2'd1,
    MD_DIVU = 2'd2
  } md_fn_e;

  // tag picked by the requester, echoed back in the response
  typedef logic [3:0] md_tag_t;

  // 70 bits in all
  typedef struct packed {
    md_fn_e      fn;
    logic [31:0] a;
    logic [31:0] b;
    md_tag_t     tag;
  } md_req_t;

  // --------------------
  // response side
  // --------------------

  // divide view, remainder in the high word
  typedef struct packed {
    logic [31:0] rem;
    logic [31:0] quot;
  } md_div_result_t;

  // one 64-bit word, read as product or as rem/quot pair
  typedef union packed {
    logic [63:0]    product;
    md_div_result_t div;
  } md_result_u;

  // 68 bits in all
  typedef struct packed {
    md_result_u result;
    md_tag_t    tag;
  } md_resp_t;

  // --------------------
  // shared by both arithmetic units
  // --------------------

  // one iteration per operand bit
  localparam int unsigned md_iter_count = 32;

  // control states of the iterative units
  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } md_state_e;

endpackage

/* rtl/imuldiv_unit.sv */
// --------------------
// multiply/divide top, requests steered by fn
// responses may return out of order, match them by tag
// --------------------

module imuldiv_unit import imuldiv_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     req_val,
  output logic     req_rdy,
  input  md_req_t  req_msg,
  output logic     resp_val,
  input  logic     resp_rdy,
  output md_resp_t resp_msg
);

  // decoded function
  logic     is_mul;
  logic     is_div;

  // unit request side
  logic     mul_in_val;
  logic     mul_in_rdy;
  logic     div_in_val;
  logic     div_in_rdy;

  // unit response side, toward the arbiter
  logic     mul_out_val;
  logic     mul_out_rdy;
  md_resp_t mul_out_msg;
  logic     div_out_val;
  logic     div_out_rdy;
  md_resp_t div_out_msg;

  // --------------------
  // steering
  // --------------------

  assign is_mul = (req_msg.fn == MD_MUL);
  assign is_div = (req_msg.fn == MD_DIV) || (req_msg.fn == MD_DIVU);

  // only the selected unit sees the valid
  assign mul_in_val = req_val & is_mul;
  assign div_in_val = req_val & is_div;

  // ready follows the selected unit
  // the unused fn code is never accepted
  always_comb begin
    if (is_mul) begin
      req_rdy = mul_in_rdy;
    end else if (is_div) begin
      req_rdy = div_in_rdy;
    end else begin
      req_rdy = 1'b0;
    end
  end

  // --------------------
  // units and arbiter
  // --------------------

  int_mul_iterative u_mul (
    .clk     (clk),
    .reset   (reset),
    .in_val  (mul_in_val),
    .in_rdy  (mul_in_rdy),
    .in_msg  (req_msg),
    .out_val (mul_out_val),
    .out_rdy (mul_out_rdy),
    .out_msg (mul_out_msg)
  );

  int_div_iterative u_div (
    .clk     (clk),
    .reset   (reset),
    .in_val  (div_in_val),
    .in_rdy  (div_in_rdy),
    .in_msg  (req_msg),
    .out_val (div_out_val),
    .out_rdy (div_out_rdy),
    .out_msg (div_out_msg)
  );

  resp_arbiter u_arb (
    .clk      (clk),
    .reset    (reset),
    .mul_val  (mul_out_val),
    .mul_rdy  (mul_out_rdy),
    .mul_msg  (mul_out_msg),
    .div_val  (div_out_val),
    .div_rdy  (div_out_rdy),
    .div_msg  (div_out_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp_msg (resp_msg)
  );

endmodule

/* rtl/int_div_iterative.sv */
// --------------------
// restoring divider, one quotient bit per cycle
// one request at a time, response held until out_rdy
// --------------------

module int_div_iterative import imuldiv_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     in_val,
  output logic     in_rdy,
  input  md_req_t  in_msg,
  output logic     out_val,
  input  logic     out_rdy,
  output md_resp_t out_msg
);

  // control state
  md_state_e   state_q;
  logic [5:0]  count_q;

  // latched request, held until the response leaves
  md_req_t     req_q;

  // remainder in the upper half, quotient shifts in from bit 0
  logic [64:0] rq_q;
  // divisor already sitting 32 bits up
  logic [64:0] dvs_q;

  logic        accept;
  logic        send;
  logic        is_signed;
  logic        a_neg;
  logic        b_neg;
  logic        b_zero;
  logic [31:0] a_mag;
  logic [31:0] b_mag;
  logic [64:0] shifted;
  logic [64:0] diff;
  logic [31:0] quot_mag;
  logic [31:0] rem_mag;

  // handshakes
  assign in_rdy  = (state_q == IDLE);
  assign out_val = (state_q == DONE);
  assign accept  = in_val & in_rdy;
  assign send    = out_val & out_rdy;

  // --------------------
  // control fsm
  // --------------------

  // calc count 0 is the magnitude setup cycle
  // counts 1..32 are the iterations, so out_val rises 33 edges after accept
  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= IDLE;
      count_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (accept) begin
            state_q <= CALC;
            count_q <= '0;
          end
        end
        CALC: begin
          // last iteration happens on this same edge
          if (count_q == 6'(md_iter_count)) begin
            state_q <= DONE;
          end
          count_q <= count_q + 6'd1;
        end
        DONE: begin
          // leave only once the arbiter has taken the response
          if (send) begin
            state_q <= IDLE;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // --------------------
  // datapath
  // --------------------

  // signs only matter for the signed divide
  always_comb begin
    is_signed = (req_q.fn == MD_DIV);
    a_neg     = is_signed & req_q.a[31];
    b_neg     = is_signed & req_q.b[31];
    b_zero    = (req_q.b == 32'd0);
    a_mag     = a_neg ? -req_q.a : req_q.a;
    b_mag     = b_neg ? -req_q.b : req_q.b;
  end

  // shift, trial subtract
  // remainder stays below 2^33 so bit 64 of diff is a true sign
  assign shifted = rq_q << 1;
  assign diff    = shifted - dvs_q;

  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= in_msg;
    end
    if (state_q == CALC) begin
      if (count_q == '0) begin
        rq_q  <= {33'd0, a_mag};
        dvs_q <= {1'b0, b_mag, 32'd0};
      end else if (diff[64]) begin
        // restore, quotient bit stays 0 from the shift
        rq_q <= shifted;
      end else begin
        rq_q <= {diff[64:1], 1'b1};
      end
    end
  end

  // --------------------
  // result
  // --------------------

  assign quot_mag = rq_q[31:0];
  assign rem_mag  = rq_q[63:32];

  // quotient truncates toward zero, remainder takes the dividend sign
  // with b == 0 the iterations leave |a| in rem, which restores to a
  always_comb begin
    out_msg.tag = req_q.tag;
    if (b_zero) begin
      out_msg.result.div.quot = '1;
    end else if (a_neg ^ b_neg) begin
      out_msg.result.div.quot = -quot_mag;
    end else begin
      out_msg.result.div.quot = quot_mag;
    end
    out_msg.result.div.rem = a_neg ? -rem_mag : rem_mag;
  end

endmodule

/* rtl/int_mul_iterative.sv */
// --------------------
// shift-and-add signed multiplier, full 64-bit product
// one request at a time, response held until out_rdy
// --------------------

module int_mul_iterative import imuldiv_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     in_val,
  output logic     in_rdy,
  input  md_req_t  in_msg,
  output logic     out_val,
  input  logic     out_rdy,
  output md_resp_t out_msg
);

  // control state
  md_state_e   state_q;
  logic [5:0]  count_q;

  // latched operands and tag
  logic [31:0] a_q;
  logic [31:0] b_q;
  md_tag_t     tag_q;

  // running sum, shifted multiplicand, multiplier bits left to scan
  logic [63:0] acc_q;
  logic [63:0] mcand_q;
  logic [31:0] mplier_q;

  logic        accept;
  logic        send;
  logic        prod_neg;
  logic [31:0] a_mag;
  logic [31:0] b_mag;

  assign in_rdy  = (state_q == IDLE);
  assign out_val = (state_q == DONE);
  assign accept  = in_val & in_rdy;
  assign send    = out_val & out_rdy;

  // --------------------
  // control fsm
  // --------------------

  // same pacing as the divider
  // one setup cycle, then 32 add steps
  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= IDLE;
      count_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (accept) begin
            state_q <= CALC;
            count_q <= '0;
          end
        end
        CALC: begin
          if (count_q == 6'(md_iter_count)) begin
            state_q <= DONE;
          end
          count_q <= count_q + 6'd1;
        end
        DONE: begin
          if (send) begin
            state_q <= IDLE;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // --------------------
  // datapath
  // --------------------

  // MD_MUL is always signed
  assign prod_neg = a_q[31] ^ b_q[31];
  assign a_mag    = a_q[31] ? -a_q : a_q;
  assign b_mag    = b_q[31] ? -b_q : b_q;

  always_ff @(posedge clk) begin
    if (accept) begin
      a_q   <= in_msg.a;
      b_q   <= in_msg.b;
      tag_q <= in_msg.tag;
    end
    if (state_q == CALC) begin
      if (count_q == '0) begin
        acc_q    <= '0;
        mcand_q  <= {32'd0, a_mag};
        mplier_q <= b_mag;
      end else begin
        // add in the multiplicand for each set multiplier bit
        if (mplier_q[0]) begin
          acc_q <= acc_q + mcand_q;
        end
        mcand_q  <= mcand_q << 1;
        mplier_q <= mplier_q >> 1;
      end
    end
  end

  // magnitudes top out at 2^62, so the negate never overflows
  always_comb begin
    out_msg.tag            = tag_q;
    out_msg.result.product = prod_neg ? -acc_q : acc_q;
  end

endmodule

/* rtl/resp_arbiter.sv */
// --------------------
// two-way round-robin on the response port, zero added latency
// grant is locked while a response is stalled
// --------------------

module resp_arbiter import imuldiv_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     mul_val,
  output logic     mul_rdy,
  input  md_resp_t mul_msg,
  input  logic     div_val,
  output logic     div_rdy,
  input  md_resp_t div_msg,
  output logic     resp_val,
  input  logic     resp_rdy,
  output md_resp_t resp_msg
);

  // priority pointer, 1 favours the divider
  logic prio_div_q;
  // a stalled response keeps its grant so resp_msg holds still
  logic hold_q;
  logic hold_div_q;

  logic sel_div;
  logic xfer;

  // --------------------
  // grant
  // --------------------

  always_comb begin
    if (hold_q) begin
      sel_div = hold_div_q;
    end else if (mul_val & div_val) begin
      sel_div = prio_div_q;
    end else begin
      sel_div = div_val;
    end
  end

  assign resp_val = mul_val | div_val;
  assign resp_msg = sel_div ? div_msg : mul_msg;
  assign xfer     = resp_val & resp_rdy;

  // only the granted unit sees ready
  assign div_rdy  = resp_rdy & sel_div;
  assign mul_rdy  = resp_rdy & ~sel_div;

  // --------------------
  // pointer and lock
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      prio_div_q <= 1'b1;
      hold_q     <= 1'b0;
      hold_div_q <= 1'b0;
    end else begin
      // after a transfer the other unit goes first
      if (xfer) begin
        prio_div_q <= ~sel_div;
      end
      hold_q     <= resp_val & ~resp_rdy;
      hold_div_q <= sel_div;
    end
  end

endmodule

/* sim.f */
rtl/imuldiv_pkg.sv
rtl/int_mul_iterative.sv
rtl/int_div_iterative.sv
rtl/resp_arbiter.sv
rtl/imuldiv_unit.sv
testbench/imuldiv_properties.sv
testbench/tb_imuldiv.sv

/* testbench/imuldiv_properties.sv */
// --------------------
// handshake assertions, bound into every imuldiv_unit
// --------------------

module imuldiv_properties import imuldiv_pkg::*; (
  input logic     clk,
  input logic     reset,
  input logic     req_val,
  input logic     req_rdy,
  input md_req_t  req_msg,
  input logic     resp_val,
  input logic     resp_rdy,
  input md_resp_t resp_msg
);

  timeunit 1ns;
  timeprecision 100ps;

  // failure count, read by the testbench at the end
  int   assert_fails = 0;
  logic req_is_div;

  assign req_is_div = (req_msg.fn == MD_DIV) || (req_msg.fn == MD_DIVU);

  // a stalled response holds still
  resp_held: assert property (
    @(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> $stable(resp_msg)
  ) else begin
    assert_fails++;
    $error("resp_msg changed while the response was stalled");
  end

  // reset leaves both units idle
  resp_idle: assert property (
    @(posedge clk) reset |=> !resp_val
  ) else begin
    assert_fails++;
    $error("resp_val high after a reset cycle");
  end

  // divider busy right after it takes a request
  div_busy: assert property (
    @(posedge clk) disable iff (reset)
    req_val && req_rdy && req_is_div |=> !(req_is_div && req_rdy)
  ) else begin
    assert_fails++;
    $error("divider ready again in the cycle after an accept");
  end

endmodule

bind imuldiv_unit imuldiv_properties u_props (.*);

/* testbench/tb_imuldiv.sv */
// --------------------
// testbench for the multiply/divide unit, responses matched by tag
// reads the bound assertion failure count at the end of the run
// --------------------

module tb_imuldiv import imuldiv_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int ready_timeout = 100;
  localparam int resp_timeout  = 200;
  localparam int num_vectors   = 18;
  localparam int num_random    = 40;
  localparam int stall_cycles  = 40;

  // one directed case, expected high word then low word
  typedef struct packed {
    md_fn_e      fn;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] exp_hi;
    logic [31:0] exp_lo;
  } vector_t;

  logic     clk = 1'b0;
  logic     reset;
  logic     req_val;
  logic     req_rdy;
  md_req_t  req_msg;
  logic     resp_val;
  logic     resp_rdy;
  md_resp_t resp_msg;

  // scoreboard, indexed by tag
  logic [63:0] exp_by_tag [16];
  logic        pending [16];

  vector_t     vectors [num_vectors];
  md_tag_t     next_tag;
  logic [31:0] lfsr_state;
  int          cycle_count = 0;
  int          checks;
  int          errors;
  int          timeouts;

  always #10 clk = ~clk;

  // rising edge count, read only between edges
  always @(posedge clk) cycle_count <= cycle_count + 1;

  imuldiv_unit u_dut (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .req_msg  (req_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp_msg (resp_msg)
  );

  // --------------------
  // helpers
  // --------------------

  // galois lfsr, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  // one lfsr step for every bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // expected {hi, lo} from the arithmetic rules
  function automatic logic [63:0] model_result(input md_fn_e fn, input logic [31:0] a,
                                               input logic [31:0] b);
    longint x;
    longint y;
    longint q;
    longint r;
    if (fn == MD_MUL) begin
      x = longint'($signed(a));
      y = longint'($signed(b));
      return x * y;
    end
    // divide by zero keeps the dividend, quotient all ones
    if (b == 32'd0) begin
      return {a, 32'hffffffff};
    end
    if (fn == MD_DIV) begin
      x = longint'($signed(a));
      y = longint'($signed(b));
    end else begin
      x = longint'({32'd0, a});
      y = longint'({32'd0, b});
    end
    // truncation toward zero, remainder carries the dividend sign
    // 64-bit math lets most negative / -1 wrap in the low word
    q = x / y;
    r = x % y;
    return {r[31:0], q[31:0]};
  endfunction

  function automatic md_req_t make_req(input md_fn_e fn, input logic [31:0] a,
                                       input logic [31:0] b);
    md_req_t r;
    r.fn     = fn;
    r.a      = a;
    r.b      = b;
    r.tag    = next_tag;
    next_tag = next_tag + 4'd1;
    return r;
  endfunction

  task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("timeout at %0t ns: %s", $time, what);
  endtask

  task automatic score_resp(input md_resp_t r);
    if (!pending[r.tag]) begin
      errors++;
      $display("unexpected or duplicate response with tag %0d at %0t ns", r.tag, $time);
    end else begin
      check(r.result.product, exp_by_tag[r.tag], $sformatf("result for tag %0d", r.tag));
      pending[r.tag] = 1'b0;
    end
  endtask

  // --------------------
  // request and response drivers
  // --------------------

  // present a request and return after its accepting edge
  // req_val stays high until the next falling edge drive
  task automatic issue(input md_req_t r, input logic [63:0] exp, output int accept_cycle);
    int waited;
    bit taken;
    waited             = 0;
    taken              = 1'b0;
    accept_cycle       = 0;
    exp_by_tag[r.tag]  = exp;
    pending[r.tag]     = 1'b1;
    @(negedge clk);
    req_val = 1'b1;
    req_msg = r;
    while (!taken && timeouts == 0) begin
      // ready is combinational on req_msg, let it settle
      #1;
      if (req_rdy) begin
        taken        = 1'b1;
        accept_cycle = cycle_count + 1;
        @(posedge clk);
      end else if (waited == ready_timeout) begin
        report_timeout("request was never accepted");
      end else begin
        waited++;
        @(negedge clk);
      end
    end
  endtask

  task automatic idle_req();
    @(negedge clk);
    req_val = 1'b0;
  endtask

  // take one response with resp_rdy high
  // latency is counted in rising edges after the accepting edge
  task automatic collect_one(input bit check_latency, input int accept_cycle);
    int waited;
    bit taken;
    waited = 0;
    taken  = 1'b0;
    while (!taken && timeouts == 0) begin
      @(negedge clk);
      resp_rdy = 1'b1;
      #1;
      if (resp_val) begin
        taken = 1'b1;
        if (check_latency) begin
          check(64'(cycle_count - accept_cycle), 64'd33, "edges from accept to resp_val");
        end
        score_resp(resp_msg);
        @(posedge clk);
      end else if (waited == resp_timeout) begin
        report_timeout("no response arrived");
      end else begin
        waited++;
      end
    end
  endtask

  // single request with no other traffic
  task automatic run_one(input md_fn_e fn, input logic [31:0] a, input logic [31:0] b,
                         input logic [63:0] exp);
    md_req_t r;
    int      acc;
    r = make_req(fn, a, b);
    issue(r, exp, acc);
    idle_req();
    collect_one(1'b1, acc);
  endtask

  // --------------------
  // scenarios
  // --------------------

  // multiply and divide in flight together
  task automatic back_to_back();
    md_req_t m;
    md_req_t d;
    int      acc;
    m = make_req(MD_MUL, 32'hfffff000, 32'h00012345);
    d = make_req(MD_DIV, 32'h87654321, 32'h00000123);
    issue(m, model_result(m.fn, m.a, m.b), acc);
    issue(d, model_result(d.fn, d.a, d.b), acc);
    idle_req();
    collect_one(1'b0, 0);
    collect_one(1'b0, 0);
  endtask

  // both units finish while the port is held off
  task automatic stall_test();
    md_req_t  m;
    md_req_t  d;
    md_resp_t held;
    int       acc;
    int       waited;
    int       i;
    m = make_req(MD_MUL, 32'h80000000, 32'h00000003);
    d = make_req(MD_DIVU, 32'hffffffff, 32'h00000010);
    @(negedge clk);
    resp_rdy = 1'b0;
    // divider goes first so the multiplier turns valid behind a held grant
    // while the pointer favours the multiplier
    issue(d, model_result(d.fn, d.a, d.b), acc);
    issue(m, model_result(m.fn, m.a, m.b), acc);
    idle_req();
    waited = 0;
    do begin
      @(negedge clk);
      #1;
      waited++;
    end while (!resp_val && waited < resp_timeout);
    if (!resp_val) begin
      report_timeout("stalled response never became valid");
    end
    held = resp_msg;
    for (i = 0; i < stall_cycles && timeouts == 0; i++) begin
      @(negedge clk);
      #1;
      check(64'(resp_val), 64'd1, "resp_val held during stall");
      check(resp_msg.result.product, held.result.product, "result held during stall");
      check(64'(resp_msg.tag), 64'(held.tag), "tag held during stall");
    end
    collect_one(1'b0, 0);
    collect_one(1'b0, 0);
    // nothing extra once both are drained
    for (i = 0; i < 3 && timeouts == 0; i++) begin
      @(negedge clk);
      #1;
      check(64'(resp_val), 64'd0, "resp_val after drain");
    end
  endtask

  task automatic load_vectors();
    // signed multiply
    vectors[0]  = '{MD_MUL,  32'h00000007, 32'h00000006, 32'h00000000, 32'h0000002a};
    vectors[1]  = '{MD_MUL,  32'hfffffffd, 32'h00000005, 32'hffffffff, 32'hfffffff1};
    vectors[2]  = '{MD_MUL,  32'hfffffffc, 32'hfffffff8, 32'h00000000, 32'h00000020};
    vectors[3]  = '{MD_MUL,  32'h80000000, 32'h80000000, 32'h40000000, 32'h00000000};
    vectors[4]  = '{MD_MUL,  32'h80000000, 32'h00000001, 32'hffffffff, 32'h80000000};
    vectors[5]  = '{MD_MUL,  32'h7fffffff, 32'h7fffffff, 32'h3fffffff, 32'h00000001};
    vectors[6]  = '{MD_MUL,  32'h80000000, 32'hffffffff, 32'h00000000, 32'h80000000};
    // signed divide, all sign mixes, then the wrapping case
    vectors[7]  = '{MD_DIV,  32'h00000014, 32'h00000003, 32'h00000002, 32'h00000006};
    vectors[8]  = '{MD_DIV,  32'hffffffec, 32'h00000003, 32'hfffffffe, 32'hfffffffa};
    vectors[9]  = '{MD_DIV,  32'h00000014, 32'hfffffffd, 32'h00000002, 32'hfffffffa};
    vectors[10] = '{MD_DIV,  32'hffffffec, 32'hfffffffd, 32'hfffffffe, 32'h00000006};
    vectors[11] = '{MD_DIV,  32'h80000000, 32'hffffffff, 32'h00000000, 32'h80000000};
    // unsigned divide
    vectors[12] = '{MD_DIVU, 32'hffffffec, 32'h00000003, 32'h00000002, 32'h5555554e};
    vectors[13] = '{MD_DIVU, 32'h80000000, 32'hffffffff, 32'h80000000, 32'h00000000};
    vectors[14] = '{MD_DIVU, 32'h00000064, 32'h00000007, 32'h00000002, 32'h0000000e};
    // divide by zero
    vectors[15] = '{MD_DIV,  32'h12345678, 32'h00000000, 32'h12345678, 32'hffffffff};
    vectors[16] = '{MD_DIV,  32'hffffff85, 32'h00000000, 32'hffffff85, 32'hffffffff};
    vectors[17] = '{MD_DIVU, 32'hdeadbeef, 32'h00000000, 32'hdeadbeef, 32'hffffffff};
  endtask

  // --------------------
  // main sequence
  // --------------------

  initial begin
    int          i;
    md_fn_e      fn;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    reset      = 1'b1;
    req_val    = 1'b0;
    req_msg    = '0;
    resp_rdy   = 1'b0;
    next_tag   = '0;
    lfsr_state = 32'd89;
    checks     = 0;
    errors     = 0;
    timeouts   = 0;
    for (i = 0; i < 16; i++) begin
      pending[i]    = 1'b0;
      exp_by_tag[i] = '0;
    end
    load_vectors();
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    for (i = 0; i < num_vectors; i++) begin
      run_one(vectors[i].fn, vectors[i].a, vectors[i].b,
              {vectors[i].exp_hi, vectors[i].exp_lo});
    end

    for (i = 0; i < num_random; i++) begin
      r = rand_bits(2);
      case (r[1:0])
        2'd0:    fn = MD_MUL;
        2'd1:    fn = MD_DIV;
        default: fn = MD_DIVU;
      endcase
      a = rand_bits(32);
      b = rand_bits(32);
      // shrink the divisor for wider quotients, sometimes down to zero
      r = rand_bits(5);
      b = b >> r[4:0];
      run_one(fn, a, b, model_result(fn, a, b));
    end

    back_to_back();
    stall_test();

    for (i = 0; i < 16; i++) begin
      if (pending[i]) begin
        errors++;
        $display("response for tag %0d never arrived", i);
      end
    end
    $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
             checks, errors, timeouts, u_dut.u_props.assert_fails);
    if (errors == 0 && timeouts == 0 && u_dut.u_props.assert_fails == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
